// ==== logic/dpc_config.svh ====
`ifndef DPC_CONFIG_SVH
`define DPC_CONFIG_SVH

// tracked instructions in flight
// one entry per instruction between fetch queue and retire
`define DPC_TRACE_N 4

// instruction id width, must cover the ids the pipeline hands out
`define DPC_ID_W 4

// 1: single-cycle results go to the decode read ports via bypass,
// so only long instructions raise a decode RAW hazard
// 0: no bypass network, every in-flight writer stalls decode
`define DPC_ALU_BYPASS 1

`endif

// ==== logic/dpc_pkg.sv ====
`default_nettype none

`include "dpc_config.svh"

package dpc_pkg;

	typedef logic [4:0] reg_idx_t; // x0..x31
	typedef logic [`DPC_ID_W-1:0] inst_id_t;

	// life stage of one tracked instruction
	typedef enum logic [1:0]
	{
		STG_FREE,
		STG_IFQ, // sitting in the fetch queue
		STG_DSPTC, // held in the dispatch message
		STG_EXU // executing
	} dpc_stage_e;

	typedef struct packed
	{
		logic valid;
		inst_id_t id;
		reg_idx_t rd;
		logic rd_vld;
		logic is_long; // multi-cycle result, no bypass
	} enter_req_t;

	// decode, dispatch and retire strobes
	typedef struct packed
	{
		logic valid;
		inst_id_t id;
	} stage_evt_t;

	typedef struct packed
	{
		dpc_stage_e stage;
		reg_idx_t rd; // zero when no rd is written
		logic is_long;
	} entry_view_t;

	typedef struct packed
	{
		reg_idx_t imem_rs1; // indirect jump base
		reg_idx_t dcd_rs1;
		reg_idx_t dcd_rs2;
		reg_idx_t dsptc_rd;
	} check_req_t;

	typedef struct packed
	{
		logic imem_rs1_raw;
		logic dcd_rs1_raw;
		logic dcd_rs2_raw;
		logic dsptc_rd_waw;
		logic p0_bypass;
		logic p1_bypass;
	} check_res_t;

endpackage

`default_nettype wire

// ==== logic/dpc_trace_entry.sv ====
`default_nettype none

module dpc_trace_entry
(
	input wire clk,
	input wire resetn,
	input wire alloc_i, // granted by the table, already qualified by enter valid
	input wire dpc_pkg::enter_req_t enter_i,
	input wire dpc_pkg::stage_evt_t dcd_i,
	input wire dpc_pkg::stage_evt_t dsptc_i,
	input wire dpc_pkg::stage_evt_t retire_i,
	input wire flush_i,
	output logic free_o,
	output dpc_pkg::entry_view_t view_o
);

	dpc_pkg::dpc_stage_e stage_q;
	dpc_pkg::dpc_stage_e stage_d;
	dpc_pkg::inst_id_t id_q;
	dpc_pkg::reg_idx_t rd_q;
	logic long_q;

	logic dcd_hit;
	logic dsptc_hit;
	logic retire_hit;
	logic flush_kill;

	assign dcd_hit = dcd_i.valid && (dcd_i.id == id_q);
	assign dsptc_hit = dsptc_i.valid && (dsptc_i.id == id_q);
	assign retire_hit = retire_i.valid && (retire_i.id == id_q);

	// executing entries survive a flush, and so does one leaving dispatch right now
	assign flush_kill = flush_i && (stage_q != dpc_pkg::STG_EXU) &&
		!((stage_q == dpc_pkg::STG_DSPTC) && dsptc_hit);

	always_comb
	begin
		stage_d = stage_q;
		if (flush_kill)
			stage_d = dpc_pkg::STG_FREE;
		else
		begin
			case (stage_q)
				dpc_pkg::STG_FREE:
					if (alloc_i)
						stage_d = dpc_pkg::STG_IFQ;
				dpc_pkg::STG_IFQ:
					if (dcd_hit)
						stage_d = dpc_pkg::STG_DSPTC;
				dpc_pkg::STG_DSPTC:
					if (dsptc_hit)
						stage_d = retire_hit ? dpc_pkg::STG_FREE : dpc_pkg::STG_EXU;
				dpc_pkg::STG_EXU:
					if (retire_hit)
						stage_d = dpc_pkg::STG_FREE;
				default:
					stage_d = dpc_pkg::STG_FREE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			stage_q <= dpc_pkg::STG_FREE;
		else
			stage_q <= stage_d;
	end

	// captured once per allocation
	always_ff @(posedge clk)
	begin
		if (alloc_i)
		begin
			id_q <= enter_i.id;
			rd_q <= enter_i.rd_vld ? enter_i.rd : '0; // no rd behaves like x0
			long_q <= enter_i.is_long;
		end
	end

	assign free_o = (stage_q == dpc_pkg::STG_FREE);
	assign view_o = '{stage: stage_q, rd: rd_q, is_long: long_q};

	a_alloc_when_free: assert property (@(posedge clk) disable iff (!resetn)
		alloc_i |-> (stage_q == dpc_pkg::STG_FREE))
		else $error("entry allocated while busy");

	// pipeline keeps each instruction at least a cycle in fetch queue and dispatch
	a_no_retire_from_ifq: assert property (@(posedge clk) disable iff (!resetn)
		(stage_q == dpc_pkg::STG_IFQ) |-> !retire_hit)
		else $error("retire of an instruction still in the fetch queue");

endmodule

`default_nettype wire

// ==== logic/dpc_trace_table.sv ====
`default_nettype none

`include "dpc_config.svh"

module dpc_trace_table
(
	input wire clk,
	input wire resetn,
	input wire dpc_pkg::enter_req_t enter_i,
	input wire dpc_pkg::stage_evt_t dcd_i,
	input wire dpc_pkg::stage_evt_t dsptc_i,
	input wire dpc_pkg::stage_evt_t retire_i,
	input wire flush_i, // flush or system reset
	output logic full_o,
	output dpc_pkg::entry_view_t [`DPC_TRACE_N-1:0] view_o
);

	logic [`DPC_TRACE_N-1:0] free_vec;
	logic [`DPC_TRACE_N-1:0] grant_vec; // one-hot, lowest free entry
	logic [`DPC_TRACE_N-1:0] alloc_vec;

	always_comb
	begin : pick_free
		logic taken;
		taken = 1'b0;
		grant_vec = '0;
		for (int i = 0; i < `DPC_TRACE_N; i++)
		begin
			if (free_vec[i] && !taken)
			begin
				grant_vec[i] = 1'b1;
				taken = 1'b1;
			end
		end
	end

	assign alloc_vec = grant_vec & {`DPC_TRACE_N{enter_i.valid}};
	assign full_o = ~|free_vec;

	genvar g;
	for (g = 0; g < `DPC_TRACE_N; g++)
	begin : g_entry
		dpc_trace_entry u_entry
		(
			.clk(clk),
			.resetn(resetn),
			.alloc_i(alloc_vec[g]),
			.enter_i(enter_i),
			.dcd_i(dcd_i),
			.dsptc_i(dsptc_i),
			.retire_i(retire_i),
			.flush_i(flush_i),
			.free_o(free_vec[g]),
			.view_o(view_o[g])
		);
	end

	// fetch must stall on full, otherwise the instruction goes untracked
	a_no_enter_when_full: assert property (@(posedge clk) disable iff (!resetn)
		enter_i.valid |-> !full_o)
		else $error("enter while trace table full");

endmodule

`default_nettype wire

// ==== logic/dpc_hazard_check.sv ====
`default_nettype none

`include "dpc_config.svh"

module dpc_hazard_check
(
	input wire dpc_pkg::entry_view_t [`DPC_TRACE_N-1:0] view_i,
	input wire imem_pending_i,
	input wire dpc_pkg::check_req_t check_i,
	output dpc_pkg::check_res_t res_o
);

	localparam bit ALU_BYPASS = (`DPC_ALU_BYPASS != 0);

	// live entry writing a nonzero rd equal to idx
	function automatic logic holds(dpc_pkg::entry_view_t v, dpc_pkg::reg_idx_t idx);
		return (v.stage != dpc_pkg::STG_FREE) && (v.rd != '0) && (v.rd == idx);
	endfunction

	logic [`DPC_TRACE_N-1:0] imem_hit;
	logic [`DPC_TRACE_N-1:0] rs1_match;
	logic [`DPC_TRACE_N-1:0] rs2_match;
	logic [`DPC_TRACE_N-1:0] waw_hit;
	logic [`DPC_TRACE_N-1:0] raw_mask; // writer must stall decode
	logic [`DPC_TRACE_N-1:0] byp_mask; // writer result comes off the bypass

	genvar g;
	for (g = 0; g < `DPC_TRACE_N; g++)
	begin : g_chk
		logic issued;

		// past decode, so the register read sees it as pending
		assign issued = (view_i[g].stage == dpc_pkg::STG_DSPTC) ||
			(view_i[g].stage == dpc_pkg::STG_EXU);

		// jalr base port has no bypass, any in-flight writer counts
		assign imem_hit[g] = holds(view_i[g], check_i.imem_rs1);

		assign rs1_match[g] = issued && holds(view_i[g], check_i.dcd_rs1);
		assign rs2_match[g] = issued && holds(view_i[g], check_i.dcd_rs2);

		assign raw_mask[g] = view_i[g].is_long || !ALU_BYPASS;
		assign byp_mask[g] = !view_i[g].is_long && ALU_BYPASS;

		// only executing long ops can still write after the new one
		assign waw_hit[g] = (view_i[g].stage == dpc_pkg::STG_EXU) && view_i[g].is_long &&
			holds(view_i[g], check_i.dsptc_rd);
	end

	always_comb
	begin
		res_o.imem_rs1_raw = (|imem_hit) || imem_pending_i; // outstanding fetch also blocks
		res_o.dcd_rs1_raw = |(rs1_match & raw_mask);
		res_o.dcd_rs2_raw = |(rs2_match & raw_mask);
		res_o.dsptc_rd_waw = |waw_hit;
		res_o.p0_bypass = |(rs1_match & byp_mask);
		res_o.p1_bypass = |(rs2_match & byp_mask);
	end

endmodule

`default_nettype wire

// ==== logic/dpc_monitor_top.sv ====
`default_nettype none

`include "dpc_config.svh"

module dpc_monitor_top
(
	input wire clk,
	input wire resetn,

	// instruction life events from the pipeline
	input wire dpc_pkg::enter_req_t enter_i,
	input wire dpc_pkg::stage_evt_t dcd_i,
	input wire dpc_pkg::stage_evt_t dsptc_i,
	input wire dpc_pkg::stage_evt_t retire_i,

	input wire flush_i,
	input wire sys_reset_i,

	input wire imem_pending_i, // imem access still outstanding
	input wire dpc_pkg::check_req_t check_i,

	output logic full_o, // back-pressure to fetch
	output dpc_pkg::check_res_t res_o
);

	dpc_pkg::entry_view_t [`DPC_TRACE_N-1:0] view;
	logic flush;

	// both requests drop everything not yet executing
	assign flush = flush_i | sys_reset_i;

	dpc_trace_table u_table
	(
		.clk(clk),
		.resetn(resetn),
		.enter_i(enter_i),
		.dcd_i(dcd_i),
		.dsptc_i(dsptc_i),
		.retire_i(retire_i),
		.flush_i(flush),
		.full_o(full_o),
		.view_o(view)
	);

	dpc_hazard_check u_check
	(
		.view_i(view),
		.imem_pending_i(imem_pending_i),
		.check_i(check_i),
		.res_o(res_o)
	);

endmodule

`default_nettype wire

// ==== test/tb_dpc_monitor.sv ====
`default_nettype none

module tb_dpc_monitor;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int N_FIELDS = 20; // columns per line in the tests file
	localparam string TESTS_FILE = "test/dpc_tests.txt";

	// one cycle of stimulus plus the response expected after it
	typedef struct packed
	{
		dpc_pkg::enter_req_t enter;
		dpc_pkg::stage_evt_t dcd;
		dpc_pkg::stage_evt_t dsptc;
		dpc_pkg::stage_evt_t retire;
		logic flush;
		logic sys_reset;
		logic imem_pending;
		dpc_pkg::check_req_t check;
		dpc_pkg::check_res_t exp_res;
		logic exp_full;
	} test_line_t;

	logic clk;
	logic resetn;
	dpc_pkg::enter_req_t enter;
	dpc_pkg::stage_evt_t dcd;
	dpc_pkg::stage_evt_t dsptc;
	dpc_pkg::stage_evt_t retire;
	logic flush;
	logic sys_reset;
	logic imem_pending;
	dpc_pkg::check_req_t check;
	dpc_pkg::check_res_t res;
	logic full;

	test_line_t tests[$];
	int n_lines = 0;

	dpc_monitor_top u_dut
	(
		.clk(clk),
		.resetn(resetn),
		.enter_i(enter),
		.dcd_i(dcd),
		.dsptc_i(dsptc),
		.retire_i(retire),
		.flush_i(flush),
		.sys_reset_i(sys_reset),
		.imem_pending_i(imem_pending),
		.check_i(check),
		.full_o(full),
		.res_o(res)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_res(input dpc_pkg::check_res_t got, input dpc_pkg::check_res_t exp,
		input int line_no);
		if (got !== exp)
		begin
			$display("Mismatch res_o at test line %0d: got %h, expected %h", line_no, got, exp);
			abort_run("hazard flags differ from the expected value");
		end
	endtask

	task automatic check_full(input logic got, input logic exp, input int line_no);
		if (got !== exp)
		begin
			$display("Mismatch full_o at test line %0d: got %h, expected %h", line_no, got, exp);
			abort_run("full flag differs from the expected value");
		end
	endtask

	// lines that hold no numbers (comments, blank) are skipped
	task automatic load_tests();
		int fd;
		int cnt;
		string text;
		logic [7:0] v [N_FIELDS];
		test_line_t ln;
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0)
			abort_run({"cannot open the tests file ", TESTS_FILE});
		while (!$feof(fd))
		begin
			text = "";
			void'($fgets(text, fd));
			cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
				v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
			if (cnt == N_FIELDS)
			begin
				ln.enter.valid = v[0][0];
				ln.enter.id = v[1][$bits(dpc_pkg::inst_id_t)-1:0];
				ln.enter.rd = v[2][4:0];
				ln.enter.rd_vld = v[3][0];
				ln.enter.is_long = v[4][0];
				ln.dcd = '{valid: v[5][0], id: v[6][$bits(dpc_pkg::inst_id_t)-1:0]};
				ln.dsptc = '{valid: v[7][0], id: v[8][$bits(dpc_pkg::inst_id_t)-1:0]};
				ln.retire = '{valid: v[9][0], id: v[10][$bits(dpc_pkg::inst_id_t)-1:0]};
				ln.flush = v[11][0];
				ln.sys_reset = v[12][0];
				ln.imem_pending = v[13][0];
				ln.check.imem_rs1 = v[14][4:0];
				ln.check.dcd_rs1 = v[15][4:0];
				ln.check.dcd_rs2 = v[16][4:0];
				ln.check.dsptc_rd = v[17][4:0];
				ln.exp_res = v[18][5:0];
				ln.exp_full = v[19][0];
				tests.push_back(ln);
			end
			else if (cnt > 0)
				abort_run("malformed line in the tests file, wrong number of columns");
		end
		$fclose(fd);
		if (tests.size() == 0)
			abort_run("the tests file holds no test lines");
	endtask

	task automatic drive_line(input test_line_t ln);
		enter = ln.enter;
		dcd = ln.dcd;
		dsptc = ln.dsptc;
		retire = ln.retire;
		flush = ln.flush;
		sys_reset = ln.sys_reset;
		imem_pending = ln.imem_pending;
		check = ln.check;
	endtask

	// no events, check indices and imem_pending stay as they are
	task automatic drive_idle();
		enter = '0;
		dcd = '0;
		dsptc = '0;
		retire = '0;
		flush = 1'b0;
		sys_reset = 1'b0;
	endtask

	initial
	begin : watchdog
		wait (n_lines != 0);
		#(CLK_PERIOD * (n_lines + RESET_CYCLES + 1000));
		abort_run("timeout, the test sequence did not finish in time");
	end

	initial
	begin : main
		int gap;
		clk = 1'b0;
		resetn = 1'b0;
		enter = '0;
		dcd = '0;
		dsptc = '0;
		retire = '0;
		flush = 1'b0;
		sys_reset = 1'b0;
		imem_pending = 1'b0;
		check = '0;
		void'($urandom(444));
		load_tests();
		n_lines = tests.size();

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		check_res(res, '0, 0); // empty table, nothing pending
		check_full(full, 1'b0, 0);
		resetn = 1'b1;

		for (int i = 0; i < n_lines; i++)
		begin
			@(negedge clk);
			drive_line(tests[i]);
			@(posedge clk); // events taken here
			#(CLK_PERIOD / 2 - 2);
			check_res(res, tests[i].exp_res, i + 1);
			check_full(full, tests[i].exp_full, i + 1);
			gap = $urandom_range(2, 0);
			repeat (gap)
			begin
				@(negedge clk);
				drive_idle();
			end
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/dpc_tests.txt ====
# en eid rd rv lg  dv did  sv sid  rt rid  fl sr ip  ir1 rs1 rs2 wrd  res full  (hex)
# res: 20 imem_rs1_raw 10 dcd_rs1_raw 08 dcd_rs2_raw 04 dsptc_rd_waw 02 p0_bypass 01 p1_bypass
# fill the table, long x5, x0 writer, masked rd, short x7 still in the fetch queue
1 1 05 1 1  0 0  0 0  0 0  0 0 0  05 05 00 00  20 0
1 2 00 1 1  1 1  0 0  0 0  0 0 0  00 05 00 00  10 0
1 3 0c 0 1  1 2  0 0  0 0  0 0 0  00 05 00 00  10 0
1 4 07 1 0  1 3  0 0  0 0  0 0 0  00 05 07 00  10 1
# x5 executing long, x7 short in dispatch
0 0 00 0 0  1 4  1 1  0 0  0 0 0  00 05 07 05  15 1
0 0 00 0 0  0 0  1 2  0 0  0 0 1  0c 0c 07 00  21 1
# retire frees a slot
0 0 00 0 0  0 0  0 0  1 2  0 0 0  00 07 05 07  0a 0
0 0 00 0 0  0 0  1 4  0 0  0 0 0  07 07 00 07  22 0
0 0 00 0 0  0 0  0 0  1 4  0 0 1  07 07 00 05  24 0
0 0 00 0 0  0 0  0 0  0 0  0 0 0  07 00 05 05  0c 0
# refill, then flush with a dispatch in the same cycle
1 5 06 1 0  0 0  1 3  0 0  0 0 0  06 06 00 00  20 0
1 6 08 1 1  1 5  0 0  1 3  0 0 0  00 06 08 00  02 0
1 7 09 1 1  1 6  0 0  0 0  0 0 0  09 08 09 00  30 1
0 0 00 0 0  0 0  1 6  0 0  1 0 0  09 05 06 08  14 0
0 0 00 0 0  0 0  0 0  0 0  0 0 0  06 08 05 05  1c 0
# system reset request drops the fetch queue too
1 8 0a 1 0  0 0  0 0  0 0  0 0 0  0a 00 00 00  20 0
0 0 00 0 0  0 0  0 0  0 0  0 1 0  0a 05 00 00  10 0
# dispatch and retire of one id in the same cycle
1 9 0b 1 1  0 0  0 0  0 0  0 0 0  0b 0b 00 00  20 0
0 0 00 0 0  1 9  0 0  0 0  0 0 0  00 0b 00 00  10 0
0 0 00 0 0  0 0  1 9  1 9  0 0 0  0b 0b 0b 0b  00 0
# drain
0 0 00 0 0  0 0  0 0  1 1  0 0 0  00 05 00 08  04 0
0 0 00 0 0  0 0  0 0  1 6  0 0 0  00 00 00 08  00 0
0 0 00 0 0  0 0  0 0  0 0  0 0 1  00 00 00 00  20 0

// ==== project.f ====
+incdir+logic
logic/dpc_pkg.sv
logic/dpc_trace_entry.sv
logic/dpc_trace_table.sv
logic/dpc_hazard_check.sv
logic/dpc_monitor_top.sv
test/tb_dpc_monitor.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= project.f
TOP        ?= tb_dpc_monitor
RTL_TOP    ?= dpc_monitor_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation reads its tests file relative to the project root
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
